// File: Bender.yml
package:
  name: wb_stage

sources:
  - rtl/wb_pkg.sv
  - rtl/wb_stage.sv
  - rtl/csr_file.sv
  - rtl/wb_commit.sv
  - rtl/wb_top.sv
  - target: test
    files:
      - testbench/wb_tb.sv

// File: project.f
rtl/wb_pkg.sv
rtl/wb_stage.sv
rtl/csr_file.sv
rtl/wb_commit.sv
rtl/wb_top.sv
testbench/wb_tb.sv

// File: rtl/csr_file.sv
module csr_file #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  wb_pkg::csr_cmd_t    csr_cmd,
    output logic [31:0]         csr_rvalue,
    output logic [31:0]         csr_eentry,
    output logic [31:0]         csr_era
);

    localparam int SAVE_IDX_W = (SAVE_COUNT > 1) ? $clog2(SAVE_COUNT) : 1;

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] save_regs [SAVE_COUNT];

    logic                  wr_en;
    logic [13:0]           save_off;
    logic                  save_hit;
    logic [SAVE_IDX_W-1:0] save_idx;
    logic [31:0]           rd_raw;

    // Old value with the bits selected by both masks taken from wvalue.
    function automatic logic [31:0] merge_bits(
        input logic [31:0] old_value,
        input logic [31:0] field_mask,
        input logic [31:0] op_mask,
        input logic [31:0] new_value
    );
        logic [31:0] m;
        m = field_mask & op_mask;
        return (old_value & ~m) | (new_value & m);
    endfunction

    assign wr_en    = csr_cmd.valid & csr_cmd.we;
    assign save_off = csr_cmd.num - wb_pkg::CSR_SAVE0;
    assign save_hit = (csr_cmd.num >= wb_pkg::CSR_SAVE0) && (save_off < 14'(SAVE_COUNT));
    assign save_idx = save_off[SAVE_IDX_W-1:0];

    // ******************************
    // Read side
    // ******************************
    always_comb begin
        rd_raw = 32'h0;  // Unimplemented numbers read as zero.
        case (csr_cmd.num)
            wb_pkg::CSR_CRMD:   rd_raw = crmd;
            wb_pkg::CSR_PRMD:   rd_raw = prmd;
            wb_pkg::CSR_ESTAT:  rd_raw = estat;
            wb_pkg::CSR_ERA:    rd_raw = era;
            wb_pkg::CSR_EENTRY: rd_raw = eentry;
            default: begin
                if (save_hit) begin
                    rd_raw = save_regs[save_idx];
                end
            end
        endcase
    end

    assign csr_rvalue = csr_cmd.re ? rd_raw : 32'h0;
    assign csr_eentry = eentry;
    assign csr_era    = era;

    // ******************************
    // Privilege state
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= 32'h0;  // PLV 0, interrupts off.
        end else if (csr_cmd.ex) begin
            crmd[2:0] <= 3'b000;
        end else if (csr_cmd.ertn) begin
            crmd[2:0] <= prmd[2:0];
        end else if (wr_en && csr_cmd.num == wb_pkg::CSR_CRMD) begin
            crmd <= merge_bits(crmd, wb_pkg::CRMD_WMASK, csr_cmd.wmask, csr_cmd.wvalue);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= 32'h0;
        end else if (csr_cmd.ex) begin
            prmd[2:0] <= crmd[2:0];  // Save PLV and IE.
        end else if (wr_en && csr_cmd.num == wb_pkg::CSR_PRMD) begin
            prmd <= merge_bits(prmd, wb_pkg::PRMD_WMASK, csr_cmd.wmask, csr_cmd.wvalue);
        end
    end

    // ******************************
    // Exception state
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            estat <= 32'h0;
        end else if (csr_cmd.ex) begin
            estat[21:16] <= wb_pkg::ECODE_SYS;
        end else if (wr_en && csr_cmd.num == wb_pkg::CSR_ESTAT) begin
            estat <= merge_bits(estat, wb_pkg::ESTAT_WMASK, csr_cmd.wmask, csr_cmd.wvalue);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era <= 32'h0;
        end else if (csr_cmd.ex) begin
            era <= csr_cmd.pc;  // Return address is the syscall itself.
        end else if (wr_en && csr_cmd.num == wb_pkg::CSR_ERA) begin
            era <= merge_bits(era, wb_pkg::ERA_WMASK, csr_cmd.wmask, csr_cmd.wvalue);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry <= 32'h0;
        end else if (wr_en && csr_cmd.num == wb_pkg::CSR_EENTRY) begin
            eentry <= merge_bits(eentry, wb_pkg::EENTRY_WMASK, csr_cmd.wmask,
                                 csr_cmd.wvalue);
        end
    end

    // ******************************
    // Scratch registers
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SAVE_COUNT; i++) begin
                save_regs[i] <= 32'h0;
            end
        end else if (wr_en && save_hit) begin
            save_regs[save_idx] <= merge_bits(save_regs[save_idx], 32'hffff_ffff,
                                              csr_cmd.wmask, csr_cmd.wvalue);
        end
    end

endmodule

// File: rtl/wb_commit.sv
module wb_commit (
    input  logic                 ws_valid,
    input  wb_pkg::ms_to_ws_t    ws_item,
    input  logic [31:0]          csr_rvalue,
    input  logic [31:0]          csr_eentry,
    input  logic [31:0]          csr_era,
    output wb_pkg::rf_bus_t      rf_bus,
    output wb_pkg::redirect_t    redirect,
    output logic [31:0]          debug_wb_pc,
    output logic [3:0]           debug_wb_rf_we,
    output logic [4:0]           debug_wb_rf_wnum,
    output logic [31:0]          debug_wb_rf_wdata
);

    logic csr_to_rf;
    logic take_syscall;
    logic take_ertn;

    // CSR ops return the old CSR value to rd.
    assign csr_to_rf = ws_item.csr_op.csrrd
                     | ws_item.csr_op.csrwr
                     | ws_item.csr_op.csrxchg;

    // ******************************
    // Register file write
    // ******************************
    always_comb begin
        rf_bus.valid = ws_valid;
        rf_bus.we    = ws_valid & ws_item.gr_we;
        rf_bus.waddr = ws_item.dest;
        rf_bus.wdata = csr_to_rf ? csr_rvalue : ws_item.final_result;
    end

    // ******************************
    // Fetch redirect
    // ******************************
    assign take_syscall = ws_valid & ws_item.csr_op.syscall;
    assign take_ertn    = ws_valid & ws_item.csr_op.ertn;

    always_comb begin
        redirect.flush   = take_syscall | take_ertn;
        redirect.is_ertn = take_ertn;
        redirect.target  = take_ertn ? csr_era : csr_eentry;
    end

    // Trace mirrors the register write.
    assign debug_wb_pc       = ws_item.pc;
    assign debug_wb_rf_we    = {4{rf_bus.we}};
    assign debug_wb_rf_wnum  = rf_bus.waddr;
    assign debug_wb_rf_wdata = rf_bus.wdata;

endmodule

// File: rtl/wb_pkg.sv
package wb_pkg;

    // ******************************
    // CSR numbers
    // ******************************
    localparam logic [13:0] CSR_CRMD   = 14'h0000;
    localparam logic [13:0] CSR_PRMD   = 14'h0001;
    localparam logic [13:0] CSR_ESTAT  = 14'h0005;
    localparam logic [13:0] CSR_ERA    = 14'h0006;
    localparam logic [13:0] CSR_EENTRY = 14'h000c;
    localparam logic [13:0] CSR_SAVE0  = 14'h0030;  // SAVE n at CSR_SAVE0 + n.

    // ******************************
    // Software-writable bits
    // ******************************
    localparam logic [31:0] CRMD_WMASK   = 32'h0000_0007;  // PLV and IE.
    localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;  // PPLV and PIE.
    localparam logic [31:0] ESTAT_WMASK  = 32'h0000_0003;  // Software interrupt bits.
    localparam logic [31:0] ERA_WMASK    = 32'hffff_ffff;
    localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0;  // Entry is 64-byte aligned.

    localparam logic [5:0] ECODE_SYS = 6'h0b;

    // One-hot op of the retiring instruction.
    typedef struct packed {
        logic csrrd;
        logic csrwr;
        logic csrxchg;
        logic ertn;
        logic syscall;
    } csr_op_t;

    // Item handed over by the memory stage.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] final_result;
        logic [4:0]  dest;
        logic        gr_we;
        csr_op_t     csr_op;
        logic [13:0] csr_num;
        logic [31:0] csr_wvalue;  // rd operand.
        logic [31:0] csr_wmask;   // rj operand, csrxchg only.
    } ms_to_ws_t;

    // Command from the stage register to the CSR file.
    typedef struct packed {
        logic        valid;
        logic        re;
        logic        we;
        logic [13:0] num;
        logic [31:0] wvalue;
        logic [31:0] wmask;
        logic        ex;
        logic        ertn;
        logic [31:0] pc;
    } csr_cmd_t;

    // Register file write port.
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_bus_t;

    // Fetch redirect on exception entry or return.
    typedef struct packed {
        logic        flush;
        logic        is_ertn;
        logic [31:0] target;
    } redirect_t;

endpackage

// File: rtl/wb_stage.sv
module wb_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ms_to_ws_valid,
    input  wb_pkg::ms_to_ws_t    ms_to_ws_bus,
    input  logic                 flush,
    output logic                 ws_allowin,
    output logic                 ws_valid,
    output wb_pkg::ms_to_ws_t    ws_item,
    output wb_pkg::csr_cmd_t     csr_cmd
);

    logic is_csr_access;
    logic is_csr_write;

    // ******************************
    // Handshake and stage register
    // ******************************
    assign ws_allowin = 1'b1;  // Writeback never stalls.

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (flush) begin
            ws_valid <= 1'b0;  // Exception or ertn kills the next item.
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_item <= ms_to_ws_bus;
        end
    end

    // ******************************
    // CSR command decode
    // ******************************
    assign is_csr_access = ws_item.csr_op.csrrd
                         | ws_item.csr_op.csrwr
                         | ws_item.csr_op.csrxchg;
    assign is_csr_write  = ws_item.csr_op.csrwr | ws_item.csr_op.csrxchg;

    always_comb begin
        csr_cmd.valid  = ws_valid;
        csr_cmd.re     = ws_valid & is_csr_access;
        csr_cmd.we     = ws_valid & is_csr_write;
        csr_cmd.num    = ws_item.csr_num;
        csr_cmd.wvalue = ws_item.csr_wvalue;
        // Plain csrwr writes every writable bit.
        csr_cmd.wmask  = ws_item.csr_op.csrxchg ? ws_item.csr_wmask : 32'hffff_ffff;
        csr_cmd.ex     = ws_valid & ws_item.csr_op.syscall;
        csr_cmd.ertn   = ws_valid & ws_item.csr_op.ertn;
        csr_cmd.pc     = ws_item.pc;
    end

endmodule

// File: rtl/wb_top.sv
module wb_top #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ms_to_ws_valid,
    input  wb_pkg::ms_to_ws_t    ms_to_ws_bus,
    output logic                 ws_allowin,
    output wb_pkg::rf_bus_t      rf_bus,
    output wb_pkg::redirect_t    redirect,
    output logic [31:0]          debug_wb_pc,
    output logic [3:0]           debug_wb_rf_we,
    output logic [4:0]           debug_wb_rf_wnum,
    output logic [31:0]          debug_wb_rf_wdata
);

    logic               ws_valid;
    wb_pkg::ms_to_ws_t  ws_item;
    wb_pkg::csr_cmd_t   csr_cmd;
    logic [31:0]        csr_rvalue;
    logic [31:0]        csr_eentry;
    logic [31:0]        csr_era;

    wb_stage u_stage (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .flush          (redirect.flush),
        .ws_allowin     (ws_allowin),
        .ws_valid       (ws_valid),
        .ws_item        (ws_item),
        .csr_cmd        (csr_cmd)
    );

    csr_file #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_csr (
        .clk        (clk),
        .reset      (reset),
        .csr_cmd    (csr_cmd),
        .csr_rvalue (csr_rvalue),
        .csr_eentry (csr_eentry),
        .csr_era    (csr_era)
    );

    wb_commit u_commit (
        .ws_valid          (ws_valid),
        .ws_item           (ws_item),
        .csr_rvalue        (csr_rvalue),
        .csr_eentry        (csr_eentry),
        .csr_era           (csr_era),
        .rf_bus            (rf_bus),
        .redirect          (redirect),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// File: testbench/wb_patterns.txt
# v pc final_result dest gr_we op csr_num wvalue wmask | rf_valid rf_we waddr wdata flush ertn target
# op bits: 10 csrrd, 08 csrwr, 04 csrxchg, 02 ertn, 01 syscall; expected values are for the next cycle
1 1c000000 11111111 01 1 00 0000 00000000 00000000 1 1 01 11111111 0 0 00000000
1 1c000004 22222222 02 0 00 0000 00000000 00000000 1 0 02 22222222 0 0 00000000
0 1c000008 33333333 03 1 00 0000 00000000 00000000 0 0 00 00000000 0 0 00000000
1 1c00000c 44444444 1f 1 00 0000 00000000 00000000 1 1 1f 44444444 0 0 00000000
1 1c000010 deadbeef 04 1 08 000c 1c0080ff 00000000 1 1 04 00000000 0 0 00000000
1 1c000014 deadbeef 05 1 10 000c 00000000 00000000 1 1 05 1c0080c0 0 0 00000000
1 1c000018 deadbeef 06 1 08 0031 a5a5a5a5 00000000 1 1 06 00000000 0 0 00000000
1 1c00001c deadbeef 07 1 08 0033 12345678 00000000 1 1 07 00000000 0 0 00000000
1 1c000020 deadbeef 08 1 10 0031 00000000 00000000 1 1 08 a5a5a5a5 0 0 00000000
1 1c000024 deadbeef 09 1 04 0031 5a5a0000 ffff0000 1 1 09 a5a5a5a5 0 0 00000000
1 1c000028 deadbeef 0a 1 10 0031 00000000 00000000 1 1 0a 5a5aa5a5 0 0 00000000
1 1c00002c deadbeef 0b 1 04 0000 ffffffff 00000005 1 1 0b 00000000 0 0 00000000
1 1c000030 deadbeef 0c 1 10 0000 00000000 00000000 1 1 0c 00000005 0 0 00000000
1 1c000040 00000000 00 0 01 0000 00000000 00000000 1 0 00 00000000 1 0 1c0080c0
1 1c000044 deadbeef 0d 1 08 0030 ffffffff 00000000 0 0 00 00000000 0 0 00000000
1 1c0080c0 deadbeef 0e 1 10 0006 00000000 00000000 1 1 0e 1c000040 0 0 00000000
1 1c0080c4 deadbeef 0f 1 10 0005 00000000 00000000 1 1 0f 000b0000 0 0 00000000
1 1c0080c8 deadbeef 10 1 10 0001 00000000 00000000 1 1 10 00000005 0 0 00000000
1 1c0080cc deadbeef 11 1 10 0030 00000000 00000000 1 1 11 00000000 0 0 00000000
1 1c0080d0 deadbeef 12 1 08 0001 fffffff6 00000000 1 1 12 00000005 0 0 00000000
1 1c0080d4 deadbeef 13 1 10 0000 00000000 00000000 1 1 13 00000000 0 0 00000000
1 1c0080d8 00000000 00 0 02 0000 00000000 00000000 1 0 00 00000000 1 1 1c000040
1 1c0080dc 99999999 14 1 00 0000 00000000 00000000 0 0 00 00000000 0 0 00000000
1 1c000040 deadbeef 15 1 10 0000 00000000 00000000 1 1 15 00000006 0 0 00000000
1 1c000044 deadbeef 16 1 10 0040 00000000 00000000 1 1 16 00000000 0 0 00000000
1 1c000048 deadbeef 17 1 08 0034 ffffffff 00000000 1 1 17 00000000 0 0 00000000
1 1c00004c deadbeef 18 1 10 0034 00000000 00000000 1 1 18 00000000 0 0 00000000
1 1c000050 deadbeef 19 1 10 0033 00000000 00000000 1 1 19 12345678 0 0 00000000
1 1c000054 deadbeef 1a 1 08 0005 ffffffff 00000000 1 1 1a 000b0000 0 0 00000000
1 1c000058 deadbeef 1b 1 10 0005 00000000 00000000 1 1 1b 000b0003 0 0 00000000
1 1c00005c cafef00d 1c 1 00 0000 00000000 00000000 1 1 1c cafef00d 0 0 00000000

// File: testbench/wb_tb.sv
module wb_tb;

    logic                clk;
    logic                reset;
    logic                ms_to_ws_valid;
    wb_pkg::ms_to_ws_t   ms_to_ws_bus;
    logic                ws_allowin;
    wb_pkg::rf_bus_t     rf_bus;
    wb_pkg::redirect_t   redirect;
    logic [31:0]         debug_wb_pc;
    logic [3:0]          debug_wb_rf_we;
    logic [4:0]          debug_wb_rf_wnum;
    logic [31:0]         debug_wb_rf_wdata;

    // Pattern table, one entry per driven cycle.
    logic                in_valid_q [$];
    wb_pkg::ms_to_ws_t   item_q [$];
    wb_pkg::rf_bus_t     exp_rf_q [$];
    wb_pkg::redirect_t   exp_rd_q [$];

    int cycle_limit = 0;
    int cycles      = 0;

    wb_top #(
        .SAVE_COUNT (4)
    ) uut (
        .clk               (clk),
        .reset             (reset),
        .ms_to_ws_valid    (ms_to_ws_valid),
        .ms_to_ws_bus      (ms_to_ws_bus),
        .ws_allowin        (ws_allowin),
        .rf_bus            (rf_bus),
        .redirect          (redirect),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;  // Period of 4.

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on failure.");
    endtask

    // ******************************
    // Compare tasks
    // ******************************
    task automatic check_rf(input wb_pkg::rf_bus_t exp, input wb_pkg::rf_bus_t act);
        logic bad;
        bad = (act.valid !== exp.valid) || (act.we !== exp.we);
        if (exp.valid) begin
            bad = bad || (act.waddr !== exp.waddr) || (act.wdata !== exp.wdata);
        end
        if (bad) begin
            $display("ERR %0t rf_bus (v we waddr wdata) exp %b %b %h %h act %b %b %h %h",
                     $time, exp.valid, exp.we, exp.waddr, exp.wdata,
                     act.valid, act.we, act.waddr, act.wdata);
            abort_run();
        end
    endtask

    task automatic check_redirect(input wb_pkg::redirect_t exp, input wb_pkg::redirect_t act);
        logic bad;
        bad = (act.flush !== exp.flush) || (act.is_ertn !== exp.is_ertn);
        if (exp.flush) begin
            bad = bad || (act.target !== exp.target);  // Target only matters on a flush.
        end
        if (bad) begin
            $display("ERR %0t redirect exp fl=%b er=%b tgt=%h act fl=%b er=%b tgt=%h",
                     $time, exp.flush, exp.is_ertn, exp.target,
                     act.flush, act.is_ertn, act.target);
            abort_run();
        end
    endtask

    task automatic check_trace(input logic [31:0] exp_pc, input wb_pkg::rf_bus_t exp);
        logic bad;
        bad = (debug_wb_rf_we !== {4{exp.we}});
        if (exp.valid) begin
            bad = bad || (debug_wb_pc !== exp_pc) || (debug_wb_rf_wnum !== exp.waddr)
                      || (debug_wb_rf_wdata !== exp.wdata);
        end
        if (bad) begin
            $display("ERR %0t debug_wb (pc we wnum wdata) exp %h %h %h %h act %h %h %h %h",
                     $time, exp_pc, {4{exp.we}}, exp.waddr, exp.wdata,
                     debug_wb_pc, debug_wb_rf_we, debug_wb_rf_wnum, debug_wb_rf_wdata);
            abort_run();
        end
    endtask

    task automatic check_allowin(input logic act);
        if (act !== 1'b1) begin
            $display("ERR %0t ws_allowin exp=1 act=%b", $time, act);
            abort_run();
        end
    endtask

    // ******************************
    // Pattern file and driver
    // ******************************
    task automatic read_patterns();
        int                fd;
        int                n_fields;
        string             line;
        logic [31:0]       v, pc, res, dest, gwe, op, num, wv;
        logic [31:0]       wm, rv, rwe, wa, wd, fl, er, tg;
        wb_pkg::ms_to_ws_t item;
        wb_pkg::rf_bus_t   rf;
        wb_pkg::redirect_t rd;
        fd = $fopen("testbench/wb_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file testbench/wb_patterns.txt.");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;  // Column notes and blank lines.
            end
            n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               v, pc, res, dest, gwe, op, num, wv,
                               wm, rv, rwe, wa, wd, fl, er, tg);
            if (n_fields != 16) begin
                $display("Pattern line has %0d fields instead of 16: %s", n_fields, line);
                abort_run();
            end
            item.pc           = pc;
            item.final_result = res;
            item.dest         = dest[4:0];
            item.gr_we        = gwe[0];
            item.csr_op       = op[4:0];
            item.csr_num      = num[13:0];
            item.csr_wvalue   = wv;
            item.csr_wmask    = wm;
            rf.valid          = rv[0];
            rf.we             = rwe[0];
            rf.waddr          = wa[4:0];
            rf.wdata          = wd;
            rd.flush          = fl[0];
            rd.is_ertn        = er[0];
            rd.target         = tg;
            in_valid_q.push_back(v[0]);
            item_q.push_back(item);
            exp_rf_q.push_back(rf);
            exp_rd_q.push_back(rd);
        end
        $fclose(fd);
        if (in_valid_q.size() == 0) begin
            $display("The pattern file holds no patterns.");
            abort_run();
        end
    endtask

    task automatic drive_item(input logic valid, input wb_pkg::ms_to_ws_t item);
        ms_to_ws_valid <= valid;
        ms_to_ws_bus   <= item;
    endtask

    // ******************************
    // Main sequence
    // ******************************
    initial begin : main
        int n;
        reset          = 1'b1;
        ms_to_ws_valid = 1'b0;
        ms_to_ws_bus   = '0;
        read_patterns();
        n = in_valid_q.size();
        cycle_limit = 16 + n + 20;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // Pattern i goes in now; pattern i-1 is in the stage this cycle.
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            if (i < n) begin
                drive_item(in_valid_q[i], item_q[i]);
            end else begin
                drive_item(1'b0, '0);
            end
            @(negedge clk);
            check_allowin(ws_allowin);
            if (i == 0) begin
                check_rf('0, rf_bus);  // Stage empty right after reset.
                check_redirect('0, redirect);
                check_trace(32'h0, '0);
            end else begin
                check_rf(exp_rf_q[i-1], rf_bus);
                check_redirect(exp_rd_q[i-1], redirect);
                check_trace(item_q[i-1].pc, exp_rf_q[i-1]);
            end
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the patterns did not finish within %0d cycles.", cycle_limit);
        abort_run();
    end

endmodule
